// ==== src/cd_pkg.sv ====
// ----------------------------------------
// Shared definitions for the frame controller
// Version byte and register map
// Reset values of the configuration
// Structs passed between the pipeline stages
// ----------------------------------------
`default_nettype none

package cd_pkg;

    localparam logic [7:0] CD_VERSION = 8'h0d;

    localparam logic [4:0] REG_VERSION         = 5'h00;
    localparam logic [4:0] REG_SETTING         = 5'h02;
    localparam logic [4:0] REG_IDLE_WAIT_LEN   = 5'h04;
    localparam logic [4:0] REG_TX_PERMIT_LEN_L = 5'h05;
    localparam logic [4:0] REG_TX_PERMIT_LEN_H = 5'h06;
    localparam logic [4:0] REG_MAX_IDLE_LEN_L  = 5'h07;
    localparam logic [4:0] REG_MAX_IDLE_LEN_H  = 5'h08;
    localparam logic [4:0] REG_TX_PRE_LEN      = 5'h09;
    localparam logic [4:0] REG_FILTER          = 5'h0b;
    localparam logic [4:0] REG_DIV_LS_L        = 5'h0c;
    localparam logic [4:0] REG_DIV_LS_H        = 5'h0d;
    localparam logic [4:0] REG_DIV_HS_L        = 5'h0e;
    localparam logic [4:0] REG_DIV_HS_H        = 5'h0f;
    localparam logic [4:0] REG_INT_FLAG        = 5'h10;
    localparam logic [4:0] REG_INT_MASK        = 5'h11;
    localparam logic [4:0] REG_RX              = 5'h14;
    localparam logic [4:0] REG_TX              = 5'h15;
    localparam logic [4:0] REG_RX_CTRL         = 5'h16;
    localparam logic [4:0] REG_TX_CTRL         = 5'h17;
    localparam logic [4:0] REG_RX_ADDR         = 5'h18;
    localparam logic [4:0] REG_RX_PAGE_FLAG    = 5'h19;
    localparam logic [4:0] REG_FILTER1         = 5'h1a;
    localparam logic [4:0] REG_FILTER2         = 5'h1b;

    // 115200 bps with a 40 MHz clock
    localparam logic [15:0] DIV_LS_RESET = 16'd346;
    localparam logic [15:0] DIV_HS_RESET = 16'd346;

    localparam logic [7:0] FILTER_ANY = 8'hff;

    // Line coder settings, stored here and used outside the controller
    typedef struct packed {
        logic        full_duplex;
        logic        break_sync;
        logic        arbitration;
        logic        not_drop;
        logic        user_crc;
        logic        tx_invert;
        logic        tx_push_pull;
        logic [7:0]  idle_wait_len;
        logic [9:0]  tx_permit_len;
        logic [9:0]  max_idle_len;
        logic [1:0]  tx_pre_len;
        logic [15:0] div_ls;
        logic [15:0] div_hs;
    } cd_cfg_t;

    localparam cd_cfg_t CFG_RESET = '{
        arbitration: 1'b1,
        idle_wait_len: 8'd10,
        tx_permit_len: 10'd20,
        max_idle_len: 10'd200,
        tx_pre_len: 2'd1,
        div_ls: DIV_LS_RESET,
        div_hs: DIV_HS_RESET,
        default: '0
    };

    typedef struct packed {
        logic [7:0] filter;
        logic [7:0] filter1;
        logic [7:0] filter2;
    } cd_filter_t;

    typedef struct packed {
        logic       wr_en;
        logic [7:0] wr_addr;
        logic [7:0] wr_data;
        logic       switch_strobe;
        logic       abort;
    } cd_tx_cmd_t;

    typedef struct packed {
        logic [7:0] rd_addr;
        logic       rd_done;
        logic       clean_all;
    } cd_rx_cmd_t;

    typedef struct packed {
        logic [7:0] rd_byte;
        logic [7:0] rd_flags;
        logic       pending;
        logic       lost_pulse;
        logic       bus_idle;
    } cd_rx_status_t;

endpackage

`default_nettype wire

// ==== src/cd_csr.sv ====
// ----------------------------------------
// Host register file
// Configuration, filter and mask registers
// Interrupt flags and irq
// Page pointers and control strobes
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_csr import cd_pkg::*; (
    input  wire           clk,
    input  wire           reset_n,
    input  wire    [4:0]  csr_address,
    input  wire           csr_read,
    input  wire           csr_write,
    input  wire    [7:0]  csr_writedata,
    output logic   [7:0]  csr_readdata,
    output logic          irq,
    output cd_cfg_t       cfg,
    output cd_filter_t    filt,
    output cd_tx_cmd_t    tx_cmd,
    output cd_rx_cmd_t    rx_cmd,
    input  cd_rx_status_t rx_status,
    input  wire           tx_pending
);

    logic [7:0] int_mask;
    logic [7:0] int_flag;
    logic       rx_lost_flag;
    logic [7:0] rx_rd_addr;
    logic [7:0] tx_wr_addr;
    logic       switch_q;
    logic       abort_q;
    logic       rd_done_q;
    logic       clean_all_q;
    logic       strobe_any;

    // Flags with no source in this design read as zero
    assign int_flag = {2'b00, ~tx_pending, 1'b0, rx_lost_flag, 1'b0,
                       rx_status.pending, rx_status.bus_idle};
    assign irq = |(int_flag & int_mask);

    assign tx_cmd = '{
        wr_en: csr_write && (csr_address == REG_TX),
        wr_addr: tx_wr_addr,
        wr_data: csr_writedata,
        switch_strobe: switch_q,
        abort: abort_q
    };
    assign rx_cmd = '{rd_addr: rx_rd_addr, rd_done: rd_done_q, clean_all: clean_all_q};

    always_comb begin
        case (csr_address)
            REG_VERSION:         csr_readdata = CD_VERSION;
            REG_SETTING:         csr_readdata = {1'b0, cfg.full_duplex, cfg.break_sync,
                                                 cfg.arbitration, cfg.not_drop, cfg.user_crc,
                                                 cfg.tx_invert, cfg.tx_push_pull};
            REG_IDLE_WAIT_LEN:   csr_readdata = cfg.idle_wait_len;
            REG_TX_PERMIT_LEN_L: csr_readdata = cfg.tx_permit_len[7:0];
            REG_TX_PERMIT_LEN_H: csr_readdata = {6'd0, cfg.tx_permit_len[9:8]};
            REG_MAX_IDLE_LEN_L:  csr_readdata = cfg.max_idle_len[7:0];
            REG_MAX_IDLE_LEN_H:  csr_readdata = {6'd0, cfg.max_idle_len[9:8]};
            REG_TX_PRE_LEN:      csr_readdata = {6'd0, cfg.tx_pre_len};
            REG_FILTER:          csr_readdata = filt.filter;
            REG_DIV_LS_L:        csr_readdata = cfg.div_ls[7:0];
            REG_DIV_LS_H:        csr_readdata = cfg.div_ls[15:8];
            REG_DIV_HS_L:        csr_readdata = cfg.div_hs[7:0];
            REG_DIV_HS_H:        csr_readdata = cfg.div_hs[15:8];
            REG_INT_FLAG:        csr_readdata = int_flag;
            REG_INT_MASK:        csr_readdata = int_mask;
            REG_RX:              csr_readdata = rx_status.rd_byte;
            REG_RX_ADDR:         csr_readdata = rx_rd_addr;
            REG_RX_PAGE_FLAG:    csr_readdata = rx_status.rd_flags;
            REG_FILTER1:         csr_readdata = filt.filter1;
            REG_FILTER2:         csr_readdata = filt.filter2;
            default:             csr_readdata = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg          <= CFG_RESET;
            filt         <= '{FILTER_ANY, FILTER_ANY, FILTER_ANY};
            int_mask     <= 8'h00;
            rx_lost_flag <= 1'b0;
            rx_rd_addr   <= 8'd0;
            tx_wr_addr   <= 8'd0;
            switch_q     <= 1'b0;
            abort_q      <= 1'b0;
            rd_done_q    <= 1'b0;
            clean_all_q  <= 1'b0;
        end else begin
            switch_q    <= 1'b0;
            abort_q     <= 1'b0;
            rd_done_q   <= 1'b0;
            clean_all_q <= 1'b0;

            if (rx_status.lost_pulse)
                rx_lost_flag <= 1'b1;
            if (csr_read && csr_address == REG_RX)
                rx_rd_addr <= rx_rd_addr + 8'd1;

            if (csr_write) begin
                case (csr_address)
                    REG_SETTING:
                        {cfg.full_duplex, cfg.break_sync, cfg.arbitration, cfg.not_drop,
                         cfg.user_crc, cfg.tx_invert, cfg.tx_push_pull} <= csr_writedata[6:0];
                    REG_IDLE_WAIT_LEN:   cfg.idle_wait_len <= csr_writedata;
                    REG_TX_PERMIT_LEN_L: cfg.tx_permit_len[7:0] <= csr_writedata;
                    REG_TX_PERMIT_LEN_H: cfg.tx_permit_len[9:8] <= csr_writedata[1:0];
                    REG_MAX_IDLE_LEN_L:  cfg.max_idle_len[7:0] <= csr_writedata;
                    REG_MAX_IDLE_LEN_H:  cfg.max_idle_len[9:8] <= csr_writedata[1:0];
                    REG_TX_PRE_LEN:      cfg.tx_pre_len <= csr_writedata[1:0];
                    REG_FILTER:          filt.filter <= csr_writedata;
                    REG_DIV_LS_L:        cfg.div_ls[7:0] <= csr_writedata;
                    REG_DIV_LS_H:        cfg.div_ls[15:8] <= csr_writedata;
                    REG_DIV_HS_L:        cfg.div_hs[7:0] <= csr_writedata;
                    REG_DIV_HS_H:        cfg.div_hs[15:8] <= csr_writedata;
                    REG_INT_MASK:        int_mask <= csr_writedata;
                    REG_TX:              tx_wr_addr <= tx_wr_addr + 8'd1;
                    REG_RX_CTRL: begin
                        if (csr_writedata[0])
                            rx_rd_addr <= 8'd0;
                        rd_done_q <= csr_writedata[1];
                        if (csr_writedata[2])
                            rx_lost_flag <= 1'b0;
                        clean_all_q <= csr_writedata[4];
                    end
                    REG_TX_CTRL: begin
                        if (csr_writedata[0])
                            tx_wr_addr <= 8'd0;
                        switch_q <= csr_writedata[1];
                        abort_q  <= csr_writedata[4];
                    end
                    REG_RX_ADDR:         rx_rd_addr <= csr_writedata;
                    REG_FILTER1:         filt.filter1 <= csr_writedata;
                    REG_FILTER2:         filt.filter2 <= csr_writedata;
                    default: ;
                endcase
            end
        end
    end

    // A strobe repeats only when the host writes on consecutive cycles
    assign strobe_any = switch_q | abort_q | rd_done_q | clean_all_q;

    a_strobe_single: assert property (@(posedge clk) disable iff (!reset_n)
        strobe_any |=> (!strobe_any || $past(csr_write)));

endmodule

`default_nettype wire

// ==== src/cd_tx_ram.sv ====
// ----------------------------------------
// Transmit page, 256 bytes
// Host write port and registered read port
// Frame commit and tx_pending tracking
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_tx_ram import cd_pkg::*; (
    input  wire        clk,
    input  wire        reset_n,
    input  cd_tx_cmd_t tx_cmd,
    input  wire  [7:0] rd_addr,
    output logic [7:0] rd_data,
    output logic       frame_ready,
    output logic [7:0] frame_len,
    input  wire        busy,
    input  wire        tx_done,
    output logic       tx_pending
);

    logic [7:0] mem [0:255];
    logic       commit;

    // An empty page or a busy mover turns the switch into a no-op
    assign commit = tx_cmd.switch_strobe && !busy && !frame_ready &&
                    (tx_cmd.wr_addr != 8'd0);

    always_ff @(posedge clk) begin
        if (tx_cmd.wr_en)
            mem[tx_cmd.wr_addr] <= tx_cmd.wr_data;
        rd_data <= mem[rd_addr];
        if (commit)
            frame_len <= tx_cmd.wr_addr;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            frame_ready <= 1'b0;
            tx_pending  <= 1'b0;
        end else if (tx_cmd.abort) begin
            frame_ready <= 1'b0;
            tx_pending  <= 1'b0;
        end else if (commit) begin
            frame_ready <= 1'b1;
            tx_pending  <= 1'b1;
        end else begin
            // The mover has picked up the frame once it leaves idle
            if (busy)
                frame_ready <= 1'b0;
            if (tx_done)
                tx_pending <= 1'b0;
        end
    end

    // The mover must still be idle in the cycle a new frame is offered
    a_no_commit_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(frame_ready) |-> !busy);

endmodule

`default_nettype wire

// ==== src/cd_loopback.sv ====
// ----------------------------------------
// Loopback frame mover
// Copies a committed transmit frame into
// the receive page, filtering on byte 0
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_loopback import cd_pkg::*; (
    input  wire        clk,
    input  wire        reset_n,
    input  wire        frame_ready,
    input  wire  [7:0] frame_len,
    input  wire        abort,
    output logic [7:0] rd_addr,
    input  wire  [7:0] rd_data,
    input  cd_filter_t filt,
    output logic       wr_en,
    output logic [7:0] wr_addr,
    output logic [7:0] wr_data,
    output logic       frame_start,
    output logic       frame_end,
    output logic       tx_done,
    output logic       bus_idle
);

    typedef enum logic [1:0] {ST_IDLE, ST_FILTER, ST_COPY} state_t;

    state_t     state;
    logic [7:0] rd_ptr;
    logic [7:0] cnt;
    logic       pass;
    logic       pass_now;
    logic       pass_cur;
    logic       last;

    assign pass_now = (filt.filter == FILTER_ANY) || (rd_data == filt.filter) ||
                      (rd_data == filt.filter1) || (rd_data == filt.filter2);
    assign pass_cur = (state == ST_FILTER) ? pass_now : pass;
    assign last     = (cnt + 8'd1 == frame_len);
    assign rd_addr  = rd_ptr;
    assign bus_idle = (state == ST_IDLE);

    // rd_data holds byte cnt while the read of the next byte is in flight
    always_ff @(posedge clk) begin
        wr_addr <= cnt;
        wr_data <= rd_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            rd_ptr      <= 8'd0;
            cnt         <= 8'd0;
            pass        <= 1'b0;
            wr_en       <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            tx_done     <= 1'b0;
        end else begin
            wr_en       <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            tx_done     <= 1'b0;

            if (abort) begin
                state  <= ST_IDLE;
                rd_ptr <= 8'd0;
                cnt    <= 8'd0;
            end else if (state == ST_IDLE) begin
                if (frame_ready) begin
                    state  <= ST_FILTER;
                    rd_ptr <= 8'd1;
                end
            end else begin
                if (state == ST_FILTER) begin
                    pass        <= pass_now;
                    frame_start <= pass_now;
                    state       <= ST_COPY;
                end
                wr_en  <= pass_cur;
                cnt    <= cnt + 8'd1;
                rd_ptr <= rd_ptr + 8'd1;
                if (last) begin
                    frame_end <= pass_cur;
                    tx_done   <= 1'b1;
                    state     <= ST_IDLE;
                    rd_ptr    <= 8'd0;
                    cnt       <= 8'd0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/cd_rx_ram.sv ====
// ----------------------------------------
// Receive page, 256 bytes
// Mover write port and host read port
// Pending state, frame length, lost pulse
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_rx_ram import cd_pkg::*; (
    input  wire           clk,
    input  wire           reset_n,
    input  wire           wr_en,
    input  wire    [7:0]  wr_addr,
    input  wire    [7:0]  wr_data,
    input  wire           frame_start,
    input  wire           frame_end,
    input  cd_rx_cmd_t    rx_cmd,
    output cd_rx_status_t rx_status
);

    logic [7:0] mem [0:255];
    logic       pending;
    logic       accept;
    logic       lost_q;
    logic [7:0] len_q;
    logic [7:0] len_next;
    logic       accept_now;
    logic       wr_ok;
    logic       release_page;

    // A frame is taken only if the page was free when it started
    assign accept_now   = frame_start ? !pending : accept;
    assign wr_ok        = wr_en && accept_now;
    assign len_next     = wr_addr + 8'd1;
    assign release_page = rx_cmd.rd_done || rx_cmd.clean_all;

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
            accept  <= 1'b0;
            lost_q  <= 1'b0;
            len_q   <= 8'd0;
        end else begin
            lost_q <= frame_start && pending;
            if (frame_start)
                accept <= !pending;
            if (release_page)
                pending <= 1'b0;
            if (frame_end && accept_now) begin
                accept <= 1'b0;
                // Length 256 wraps to 0 and is dropped
                if (len_next != 8'd0) begin
                    pending <= 1'b1;
                    len_q   <= len_next;
                end
            end
        end
    end

    always_comb begin
        rx_status.rd_byte    = mem[rx_cmd.rd_addr];
        rx_status.rd_flags   = len_q;
        rx_status.pending    = pending;
        rx_status.lost_pulse = lost_q;
        // Filled in from the mover at the top level
        rx_status.bus_idle   = 1'b0;
    end

    a_no_write_on_pending: assert property (@(posedge clk) disable iff (!reset_n)
        (wr_en && pending && !release_page) |=> (pending && $stable(len_q)));

endmodule

`default_nettype wire

// ==== src/cd_ctrl_top.sv ====
// ----------------------------------------
// Frame controller top level
// Register file, transmit page, loopback
// mover and receive page
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_ctrl_top import cd_pkg::*; (
    input  wire        clk,
    input  wire        reset_n,
    input  wire  [4:0] csr_address,
    input  wire        csr_read,
    input  wire        csr_write,
    input  wire  [7:0] csr_writedata,
    output logic [7:0] csr_readdata,
    output logic       irq,
    output cd_cfg_t    cfg
);

    cd_filter_t    filt;
    cd_tx_cmd_t    tx_cmd;
    cd_rx_cmd_t    rx_cmd;
    cd_rx_status_t rx_status_ram;
    cd_rx_status_t rx_status;
    logic          tx_pending;
    logic          frame_ready;
    logic [7:0]    frame_len;
    logic [7:0]    tx_rd_addr;
    logic [7:0]    tx_rd_data;
    logic          rx_wr_en;
    logic [7:0]    rx_wr_addr;
    logic [7:0]    rx_wr_data;
    logic          frame_start;
    logic          frame_end;
    logic          tx_done;
    logic          bus_idle;

    always_comb begin
        rx_status          = rx_status_ram;
        rx_status.bus_idle = bus_idle;
    end

    cd_csr cd_csr_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .irq           (irq),
        .cfg           (cfg),
        .filt          (filt),
        .tx_cmd        (tx_cmd),
        .rx_cmd        (rx_cmd),
        .rx_status     (rx_status),
        .tx_pending    (tx_pending)
    );

    cd_tx_ram cd_tx_ram_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .tx_cmd      (tx_cmd),
        .rd_addr     (tx_rd_addr),
        .rd_data     (tx_rd_data),
        .frame_ready (frame_ready),
        .frame_len   (frame_len),
        .busy        (!bus_idle),
        .tx_done     (tx_done),
        .tx_pending  (tx_pending)
    );

    cd_loopback cd_loopback_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_ready (frame_ready),
        .frame_len   (frame_len),
        .abort       (tx_cmd.abort),
        .rd_addr     (tx_rd_addr),
        .rd_data     (tx_rd_data),
        .filt        (filt),
        .wr_en       (rx_wr_en),
        .wr_addr     (rx_wr_addr),
        .wr_data     (rx_wr_data),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .tx_done     (tx_done),
        .bus_idle    (bus_idle)
    );

    cd_rx_ram cd_rx_ram_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_en       (rx_wr_en),
        .wr_addr     (rx_wr_addr),
        .wr_data     (rx_wr_data),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .rx_cmd      (rx_cmd),
        .rx_status   (rx_status_ram)
    );

endmodule

`default_nettype wire

// ==== verif/cd_ctrl_tb.sv ====
// ----------------------------------------
// Testbench for the frame controller
// Clock, reset and vector file reader
// Host bus read, write and poll tasks
// Compare tasks for bytes, cfg and irq
// Watchdog
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cd_ctrl_tb import cd_pkg::*; ();

    localparam int POLL_LIMIT = 64;

    logic       clk;
    logic       reset_n;
    logic [4:0] csr_address;
    logic       csr_read;
    logic       csr_write;
    logic [7:0] csr_writedata;
    logic [7:0] csr_readdata;
    logic       irq;
    cd_cfg_t    cfg;

    logic [7:0] v_op [$];
    logic [7:0] v_addr [$];
    logic [7:0] v_data [$];
    logic [7:0] v_exp [$];
    int         n_vec = 0;
    bit         loaded = 1'b0;
    int         errors = 0;
    int         test_errors = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;
    cd_cfg_t    exp_cfg;

    cd_ctrl_top cd_ctrl_top_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_address   (csr_address),
        .csr_read      (csr_read),
        .csr_write     (csr_write),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .irq           (irq),
        .cfg           (cfg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Settings of the reference after reset
    function automatic cd_cfg_t cfg_reset_value();
        cd_cfg_t c;
        c = '0;
        c.arbitration   = 1'b1;
        c.idle_wait_len = 8'd10;
        c.tx_permit_len = 10'd20;
        c.max_idle_len  = 10'd200;
        c.tx_pre_len    = 2'd1;
        c.div_ls        = 16'd346;
        c.div_hs        = 16'd346;
        return c;
    endfunction

    function automatic cd_cfg_t cfg_after_write(cd_cfg_t c, logic [4:0] a, logic [7:0] d);
        cd_cfg_t n;
        n = c;
        case (a)
            REG_SETTING:
                {n.full_duplex, n.break_sync, n.arbitration, n.not_drop,
                 n.user_crc, n.tx_invert, n.tx_push_pull} = d[6:0];
            REG_IDLE_WAIT_LEN:   n.idle_wait_len = d;
            REG_TX_PERMIT_LEN_L: n.tx_permit_len[7:0] = d;
            REG_TX_PERMIT_LEN_H: n.tx_permit_len[9:8] = d[1:0];
            REG_MAX_IDLE_LEN_L:  n.max_idle_len[7:0] = d;
            REG_MAX_IDLE_LEN_H:  n.max_idle_len[9:8] = d[1:0];
            REG_TX_PRE_LEN:      n.tx_pre_len = d[1:0];
            REG_DIV_LS_L:        n.div_ls[7:0] = d;
            REG_DIV_LS_H:        n.div_ls[15:8] = d;
            REG_DIV_HS_L:        n.div_hs[7:0] = d;
            REG_DIV_HS_H:        n.div_hs[15:8] = d;
            default: ;
        endcase
        return n;
    endfunction

    task automatic check_byte(input string name, input logic [4:0] a, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s at %h: got %h, expected %h", name, a, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_cfg(input cd_cfg_t got, input cd_cfg_t exp);
        if (got !== exp) begin
            $display("[FAIL] cfg: got %h, expected %h", got, exp);
            test_errors++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] irq: got %h, expected %h", got, exp);
            test_errors++;
        end
    endtask

    task automatic bus_write(input logic [4:0] a, input logic [7:0] d);
        @(posedge clk);
        csr_address   <= a;
        csr_writedata <= d;
        csr_write     <= 1'b1;
        @(posedge clk);
        csr_write     <= 1'b0;
    endtask

    // Data is taken at the falling edge, the read strobe ends on the next rising edge
    task automatic bus_read(input logic [4:0] a, output logic [7:0] d);
        @(posedge clk);
        csr_address <= a;
        csr_read    <= 1'b1;
        @(negedge clk);
        d = csr_readdata;
        @(posedge clk);
        csr_read    <= 1'b0;
    endtask

    task automatic poll_flag(input logic [4:0] a, input logic [7:0] mask, input logic [7:0] exp);
        int         tries;
        logic [7:0] d;
        tries = 0;
        bus_read(a, d);
        while (((d & mask) !== exp) && tries < POLL_LIMIT) begin
            bus_read(a, d);
            tries++;
        end
        if ((d & mask) !== exp) begin
            $display("register %h never reached %h under mask %h, last read %h",
                     a, exp, mask, d);
            test_errors++;
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line;
        logic [7:0]       op;
        logic [7:0]       a;
        logic [7:0]       d;
        logic [7:0]       e;
        fd = $fopen("verif/cd_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/cd_ctrl_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%s %h %h %h", op, a, d, e);
                if (cnt == 4 && op != "#") begin
                    v_op.push_back(op);
                    v_addr.push_back(a);
                    v_data.push_back(d);
                    v_exp.push_back(e);
                end
            end
            $fclose(fd);
            n_vec = v_op.size();
        end
    endtask

    task automatic run_vectors();
        logic [7:0] d;
        for (int i = 0; i < n_vec; i++) begin
            case (v_op[i])
                "W": begin
                    bus_write(v_addr[i][4:0], v_data[i]);
                    exp_cfg = cfg_after_write(exp_cfg, v_addr[i][4:0], v_data[i]);
                end
                "R": begin
                    bus_read(v_addr[i][4:0], d);
                    check_byte("csr_readdata", v_addr[i][4:0], d, v_exp[i]);
                end
                "P": poll_flag(v_addr[i][4:0], v_data[i], v_exp[i]);
                "I": begin
                    @(negedge clk);
                    check_irq(irq, v_exp[i][0]);
                end
                "C": begin
                    @(negedge clk);
                    check_cfg(cfg, exp_cfg);
                end
                "T": begin
                    if (test_errors == 0) begin
                        tests_ok++;
                        $display("test %0d ok", v_addr[i]);
                    end else begin
                        tests_bad++;
                        $display("test %0d failed with %0d errors", v_addr[i], test_errors);
                    end
                    errors += test_errors;
                    test_errors = 0;
                end
                default: begin
                    $display("vector %0d has an unknown operation code", i);
                    test_errors++;
                end
            endcase
        end
        errors += test_errors;
    endtask

    initial begin
        reset_n       = 1'b0;
        csr_address   = 5'd0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = 8'd0;
        load_vectors();
        loaded = 1'b1;
        if (n_vec == 0) begin
            $display("no vectors were read, nothing was tested");
            $display("TESTS FAILED");
        end else begin
            repeat (16) @(posedge clk);
            reset_n <= 1'b1;
            exp_cfg = cfg_reset_value();
            run_vectors();
            $display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
            if (errors == 0 && tests_bad == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
        end
        $finish;
    end

    // Each vector gets a generous cycle budget, polls included
    initial begin
        wait (loaded);
        repeat (16 + n_vec * 300) @(posedge clk);
        $display("watchdog expired, the vectors did not complete in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/cd_ctrl_vectors.txt ====
# Columns: op addr data exp, all hex. W writes data, R reads and compares with exp
# P polls until (read & data) == exp, I checks irq, C checks cfg, T ends test number addr
# Reset values
R 00 00 0d
R 02 00 10
R 04 00 0a
R 07 00 c8
R 0b 00 ff
R 1a 00 ff
R 1b 00 ff
R 0c 00 5a
R 0d 00 01
R 10 00 21
I 00 00 00
C 00 00 00
T 01 00 00
# Configuration write and read back
W 02 ff 00
R 02 00 7f
W 05 a5 00
W 06 ff 00
R 05 00 a5
R 06 00 03
W 0f 12 00
R 0f 00 12
C 00 00 00
T 02 00 00
# Frame through the loopback with the filter open
W 15 03 00
W 15 a1 00
W 15 b2 00
W 15 c3 00
W 17 02 00
P 10 02 02
R 19 00 04
R 14 00 03
R 14 00 a1
R 14 00 b2
R 14 00 c3
P 10 ff 23
T 03 00 00
# Address filter drops 07 and accepts filter2
W 16 03 00
W 0b 05 00
W 1b 09 00
W 17 01 00
W 15 07 00
W 15 11 00
W 17 02 00
P 10 21 21
R 10 00 21
W 17 01 00
W 15 09 00
W 15 22 00
W 17 02 00
P 10 02 02
R 19 00 02
R 14 00 09
R 14 00 22
T 04 00 00
# Frame on a pending page is lost
W 17 01 00
W 15 09 00
W 15 44 00
W 17 02 00
P 10 21 21
R 10 00 2b
R 19 00 02
W 16 04 00
R 10 00 23
W 16 02 00
R 10 00 21
T 05 00 00
# irq under the mask
I 00 00 00
W 11 01 00
I 00 00 01
W 11 02 00
I 00 00 00
W 11 00 00
I 00 00 00
T 06 00 00

// ==== all.f ====
src/cd_pkg.sv
src/cd_csr.sv
src/cd_tx_ram.sv
src/cd_loopback.sv
src/cd_rx_ram.sv
src/cd_ctrl_top.sv
verif/cd_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the frame controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cd_ctrl_tb -o cd_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/cd_ctrl_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
